//--- include/fwd_ext_macros.svh
`ifndef FWD_EXT_MACROS_SVH
`define FWD_EXT_MACROS_SVH

// read geometry and field widths
`define READ_LEN   101 // bases per read
`define READ_NUM_W 8   // read number in flight
`define POS_W      7   // i, min_intv, backward_x, curr pointer
`define STATUS_W   6
`define QUERY_W    8
`define ADDR_W     32  // DRAM word address

// item status codes
`define ST_F_INIT  6'd0
`define ST_F_RUN   6'd1
`define ST_F_BREAK 6'd2
`define ST_BCK_INI 6'd4
`define ST_BUBBLE  6'b110000 // empty pipeline slot

`endif

//--- src/fwd_ext_pkg.sv
`include "fwd_ext_macros.svh"

package fwd_ext_pkg;

	// ----------------------------------------------------------
	// bi-interval, info sits in the top word so the packed form
	// is the curr queue entry as it is written
	typedef struct packed {
		logic [63:0] info; // start position of the match
		logic [63:0] x2;   // interval size
		logic [63:0] x1;   // reverse strand start
		logic [63:0] x0;   // forward strand start
	} bi_interval_t;

	// one candidate per base, info is not used
	typedef bi_interval_t [3:0] ok_set_t;

	// ----------------------------------------------------------
	// suffix array position, seen as a number or as a block address
	typedef union packed {
		logic [63:0] num;
		struct packed {
			logic [28:0] upper;  // beyond the addressable range
			logic [27:0] idx;    // occurrence block index
			logic [6:0]  offset; // position inside the block
		} blk;
	} bwt_pos_u;

	// ----------------------------------------------------------
	// base c selects ok[3-c], the complement strand candidate
	function automatic bi_interval_t pick_candidate(
		input ok_set_t                ok,
		input logic [`QUERY_W-1:0]    query
	);
		logic [1:0] sel;
		sel = 2'd3 - query[1:0];
		return ok[sel];
	endfunction

	// block index widened to a DRAM word address
	function automatic logic [`ADDR_W-1:0] blk_addr(
		input bwt_pos_u pos
	);
		return {pos.blk.idx, 4'b0000};
	endfunction

endpackage

//--- src/ext_stage_if.sv
`timescale 1ns/1ns
`include "fwd_ext_macros.svh"

interface ext_stage_if import fwd_ext_pkg::*; ();

	logic [`STATUS_W-1:0]   status;     // ST_BUBBLE marks an empty slot
	logic [`QUERY_W-1:0]    query;      // current base
	logic [`POS_W-1:0]      ptr_curr;   // next free curr queue entry
	logic [`READ_NUM_W-1:0] read_num;
	bi_interval_t           ik;
	logic [`POS_W-1:0]      forward_i;
	logic [`POS_W-1:0]      min_intv;
	logic [`POS_W-1:0]      backward_x;

	modport src (
		output status, query, ptr_curr, read_num,
		output ik, forward_i, min_intv, backward_x
	);

	modport dst (
		input  status, query, ptr_curr, read_num,
		input  ik, forward_i, min_intv, backward_x
	);

endinterface

//--- src/fwd_entry_stage.sv
`timescale 1ns/1ns
`include "fwd_ext_macros.svh"

module fwd_entry_stage import fwd_ext_pkg::*; (
	input  logic                   Clk_32UI,
	input  logic                   reset_BWT_extend,
	input  logic                   stall_i,

	input  logic [`STATUS_W-1:0]   status_i,
	input  logic [`QUERY_W-1:0]    query_i,
	input  logic [`POS_W-1:0]      ptr_curr_i,
	input  logic [`READ_NUM_W-1:0] read_num_i,
	input  bi_interval_t           ik_i,
	input  logic [`POS_W-1:0]      forward_i_i,
	input  logic [`POS_W-1:0]      min_intv_i,
	input  logic [`POS_W-1:0]      backward_x_i,
	input  ok_set_t                ok_i,

	ext_stage_if.src               out,
	output ok_set_t                ok_o
);

	logic [`STATUS_W-1:0] status_n;

	// ----------------------------------------------------------
	// a running item that consumed the whole read stops here
	always_comb begin
		status_n = status_i;
		if (status_i == `ST_F_RUN && forward_i_i >= `READ_LEN) begin
			status_n = `ST_F_BREAK;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			out.status <= `ST_BUBBLE;
		end
		else if (!stall_i) begin
			out.status     <= status_n;
			out.query      <= query_i;
			out.ptr_curr   <= ptr_curr_i;
			out.read_num   <= read_num_i;
			out.ik         <= ik_i;
			out.forward_i  <= forward_i_i;
			out.min_intv   <= min_intv_i;
			out.backward_x <= backward_x_i;
			ok_o           <= ok_i; // candidates stay aligned with the item
		end
	end

endmodule

//--- src/fwd_select_stage.sv
`timescale 1ns/1ns
`include "fwd_ext_macros.svh"

module fwd_select_stage import fwd_ext_pkg::*; (
	input  logic                          Clk_32UI,
	input  logic                          reset_BWT_extend,
	input  logic                          stall_i,

	ext_stage_if.dst                      in,
	input  ok_set_t                       ok_i,

	ext_stage_if.src                      out,
	output ok_set_t                       ok_o,
	output logic                          update_ik_o,

	output logic [`READ_NUM_W-1:0]        curr_read_num_o,
	output logic                          curr_we_o,
	output bi_interval_t                  curr_data_o,
	output logic [`POS_W-1:0]             curr_addr_o,

	output logic                          ret_valid_o,
	output logic [`POS_W-1:0]             ret_o,
	output logic [`READ_NUM_W-1:0]        ret_read_num_o
);

	bi_interval_t         cand;
	logic [`STATUS_W-1:0] status_n;
	logic [`POS_W-1:0]    ptr_n;
	logic                 write_n;  // push old ik into curr
	logic                 update_n; // take the candidate downstream
	logic                 ret_n;

	// ----------------------------------------------------------
	// forward step decision
	always_comb begin
		cand     = pick_candidate(ok_i, in.query);
		status_n = in.status;
		write_n  = 1'b0;
		update_n = 1'b0;
		ret_n    = 1'b0;
		case (in.status)
			`ST_F_RUN: begin
				if (in.query > 8'd3) begin // ambiguous base ends the extension
					write_n  = 1'b1;
					status_n = `ST_F_BREAK;
				end
				else if (cand.x2 != in.ik.x2) begin // interval shrank
					write_n = 1'b1;
					if (cand.x2 < 64'(in.min_intv)) begin
						status_n = `ST_F_BREAK;
					end
					else begin
						update_n = 1'b1;
					end
				end
				else begin
					update_n = 1'b1;
				end
			end
			`ST_F_BREAK: begin
				write_n  = (in.forward_i == `READ_LEN); // reached the read end
				ret_n    = 1'b1;
				status_n = `ST_BCK_INI;
			end
			default: status_n = in.status;
		endcase
		ptr_n = write_n ? in.ptr_curr + 1'b1 : in.ptr_curr;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			out.status      <= `ST_BUBBLE;
			update_ik_o     <= 1'b0;
			curr_we_o       <= 1'b0;
			curr_data_o     <= '0;
			curr_addr_o     <= '0;
			curr_read_num_o <= '0;
			ret_valid_o     <= 1'b0;
		end
		else if (!stall_i) begin
			out.status      <= status_n;
			out.ptr_curr    <= ptr_n;
			update_ik_o     <= update_n;

			curr_we_o       <= write_n;
			curr_data_o     <= write_n ? in.ik : '0;
			curr_addr_o     <= write_n ? in.ptr_curr : '0;
			curr_read_num_o <= write_n ? in.read_num : '0;

			ret_valid_o     <= ret_n;
			ret_o           <= ret_n ? in.ik.info[`POS_W-1:0] : '0; // return position
			ret_read_num_o  <= ret_n ? in.read_num : '0;

			out.query       <= in.query;
			out.read_num    <= in.read_num;
			out.ik          <= in.ik;
			out.forward_i   <= in.forward_i;
			out.min_intv    <= in.min_intv;
			out.backward_x  <= in.backward_x;
			ok_o            <= ok_i;
		end
	end

endmodule

//--- src/fwd_update_stage.sv
`timescale 1ns/1ns
`include "fwd_ext_macros.svh"

module fwd_update_stage import fwd_ext_pkg::*; (
	input  logic            Clk_32UI,
	input  logic            reset_BWT_extend,
	input  logic            stall_i,

	ext_stage_if.dst        in,
	input  ok_set_t         ok_i,
	input  logic            update_ik_i,

	ext_stage_if.src        out,
	output logic [63:0]     k_pos_o,
	output logic [63:0]     l_pos_o,
	output logic [63:0]     k_pos_m1_o,
	output logic [63:0]     l_pos_m1_o
);

	bi_interval_t           cand;
	bi_interval_t           ik_n;
	logic [`POS_W-1:0]      fwd_i_n;
	logic [63:0]            k_n;
	logic [63:0]            l_n;

	// first register level
	logic [`STATUS_W-1:0]   status_a;
	logic [`QUERY_W-1:0]    query_a;
	logic [`POS_W-1:0]      ptr_curr_a;
	logic [`READ_NUM_W-1:0] read_num_a;
	bi_interval_t           ik_a;
	logic [`POS_W-1:0]      forward_i_a;
	logic [`POS_W-1:0]      min_intv_a;
	logic [`POS_W-1:0]      backward_x_a;
	logic [63:0]            k_a, l_a, k_m1_a, l_m1_a;

	// ----------------------------------------------------------
	// ik = ok[c]; ik.info = i + 1; i++
	always_comb begin
		cand    = pick_candidate(ok_i, in.query);
		ik_n    = in.ik;
		fwd_i_n = in.forward_i;
		if (in.status == `ST_F_RUN && update_ik_i) begin
			fwd_i_n   = in.forward_i + 1'b1;
			ik_n.x0   = cand.x0;
			ik_n.x1   = cand.x1;
			ik_n.x2   = cand.x2;
			ik_n.info = 64'(fwd_i_n);
		end
		k_n = ik_n.x1 - 64'd1; // occurrence positions for the next step
		l_n = k_n + ik_n.x2;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			status_a <= `ST_BUBBLE;
		end
		else if (!stall_i) begin
			status_a     <= in.status;
			query_a      <= in.query;
			ptr_curr_a   <= in.ptr_curr;
			read_num_a   <= in.read_num;
			ik_a         <= ik_n;
			forward_i_a  <= fwd_i_n;
			min_intv_a   <= in.min_intv;
			backward_x_a <= in.backward_x;
			k_a          <= k_n;
			l_a          <= l_n;
			k_m1_a       <= k_n - 64'd1; // primary correction picks these
			l_m1_a       <= l_n - 64'd1;
		end
	end

	// ----------------------------------------------------------
	// retime, gives the compare against primary a full cycle
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			out.status <= `ST_BUBBLE;
		end
		else if (!stall_i) begin
			out.status     <= status_a;
			out.query      <= query_a;
			out.ptr_curr   <= ptr_curr_a;
			out.read_num   <= read_num_a;
			out.ik         <= ik_a;
			out.forward_i  <= forward_i_a;
			out.min_intv   <= min_intv_a;
			out.backward_x <= backward_x_a;
			k_pos_o        <= k_a;
			l_pos_o        <= l_a;
			k_pos_m1_o     <= k_m1_a;
			l_pos_m1_o     <= l_m1_a;
		end
	end

endmodule

//--- src/fwd_mem_request_stage.sv
`timescale 1ns/1ns
`include "fwd_ext_macros.svh"

module fwd_mem_request_stage import fwd_ext_pkg::*; (
	input  logic                   Clk_32UI,
	input  logic                   reset_BWT_extend,
	input  logic                   stall_i,
	input  logic [63:0]            primary_i,

	ext_stage_if.dst               in,
	input  logic [63:0]            k_pos_i,
	input  logic [63:0]            l_pos_i,
	input  logic [63:0]            k_pos_m1_i,
	input  logic [63:0]            l_pos_m1_i,

	output logic                   dram_valid_o,
	output logic [`ADDR_W-1:0]     addr_k_o,
	output logic [`ADDR_W-1:0]     addr_l_o,

	output logic [`STATUS_W-1:0]   status_o,
	output logic [`POS_W-1:0]      ptr_curr_o,
	output logic [`READ_NUM_W-1:0] read_num_o,
	output bi_interval_t           ik_o,
	output logic [`POS_W-1:0]      forward_i_o,
	output logic [`POS_W-1:0]      min_intv_o,
	output logic [`POS_W-1:0]      backward_x_o,
	output logic [`POS_W-1:0]      next_query_position_o
);

	bwt_pos_u k_sel;
	bwt_pos_u l_sel;
	logic     req; // item still extending, fetch its next blocks

	// the primary row ($) is not stored in the BWT
	always_comb begin
		k_sel.num = (k_pos_i >= primary_i) ? k_pos_m1_i : k_pos_i;
		l_sel.num = (l_pos_i >= primary_i) ? l_pos_m1_i : l_pos_i;
		req       = (in.status == `ST_F_INIT) || (in.status == `ST_F_RUN);
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			status_o     <= `ST_BUBBLE;
			dram_valid_o <= 1'b0;
			addr_k_o     <= '0;
			addr_l_o     <= '0;
		end
		else if (!stall_i) begin
			dram_valid_o <= req;
			addr_k_o     <= req ? blk_addr(k_sel) : '0;
			addr_l_o     <= req ? blk_addr(l_sel) : '0;
			status_o     <= (in.status == `ST_F_INIT) ? `ST_F_RUN : in.status;

			ptr_curr_o            <= in.ptr_curr;
			read_num_o            <= in.read_num;
			ik_o                  <= in.ik;
			forward_i_o           <= in.forward_i;
			min_intv_o            <= in.min_intv;
			backward_x_o          <= in.backward_x;
			next_query_position_o <= in.forward_i;
		end
		else begin
			// a request must not repeat while the pipeline is frozen
			dram_valid_o <= 1'b0;
			addr_k_o     <= '0;
			addr_l_o     <= '0;
		end
	end

endmodule

//--- src/fwd_ext_top.sv
`timescale 1ns/1ns
`include "fwd_ext_macros.svh"

module fwd_ext_top import fwd_ext_pkg::*; (
	input  logic                   Clk_32UI,
	input  logic                   reset_BWT_extend,
	input  logic                   stall_i,
	input  logic [63:0]            primary_i,

	input  logic [`STATUS_W-1:0]   status_i,
	input  logic [`QUERY_W-1:0]    query_i,
	input  logic [`POS_W-1:0]      ptr_curr_i,
	input  logic [`READ_NUM_W-1:0] read_num_i,
	input  logic [63:0]            ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	input  logic [`POS_W-1:0]      forward_i_i,
	input  logic [`POS_W-1:0]      min_intv_i,
	input  logic [`POS_W-1:0]      backward_x_i,
	input  logic [63:0]            ok0_x0_i, ok0_x1_i, ok0_x2_i,
	input  logic [63:0]            ok1_x0_i, ok1_x1_i, ok1_x2_i,
	input  logic [63:0]            ok2_x0_i, ok2_x1_i, ok2_x2_i,
	input  logic [63:0]            ok3_x0_i, ok3_x1_i, ok3_x2_i,

	output logic                   dram_valid_o,
	output logic [`ADDR_W-1:0]     addr_k_o, addr_l_o,
	output logic [`STATUS_W-1:0]   status_o,
	output logic [`POS_W-1:0]      ptr_curr_o,
	output logic [`READ_NUM_W-1:0] read_num_o,
	output logic [63:0]            ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o,
	output logic [`POS_W-1:0]      forward_i_o,
	output logic [`POS_W-1:0]      min_intv_o,
	output logic [`POS_W-1:0]      backward_x_o,
	output logic [`POS_W-1:0]      next_query_position_o,

	output logic [`READ_NUM_W-1:0] curr_read_num_o,
	output logic                   curr_we_o,
	output logic [255:0]           curr_data_o,
	output logic [`POS_W-1:0]      curr_addr_o,

	output logic                   ret_valid_o,
	output logic [`POS_W-1:0]      ret_o,
	output logic [`READ_NUM_W-1:0] ret_read_num_o
);

	ok_set_t      ok_in, ok_s0, ok_s1;
	bi_interval_t ik_in, ik_out;
	logic         update_ik;
	logic [63:0]  k_pos, l_pos, k_pos_m1, l_pos_m1;

	ext_stage_if s0 ();
	ext_stage_if s1 ();
	ext_stage_if s2 ();

	// ----------------------------------------------------------
	// flat ports to packed types, candidate info words are unused
	assign ik_in    = {ik_info_i, ik_x2_i, ik_x1_i, ik_x0_i};
	assign ok_in[0] = {64'd0, ok0_x2_i, ok0_x1_i, ok0_x0_i};
	assign ok_in[1] = {64'd0, ok1_x2_i, ok1_x1_i, ok1_x0_i};
	assign ok_in[2] = {64'd0, ok2_x2_i, ok2_x1_i, ok2_x0_i};
	assign ok_in[3] = {64'd0, ok3_x2_i, ok3_x1_i, ok3_x0_i};
	assign {ik_info_o, ik_x2_o, ik_x1_o, ik_x0_o} = ik_out;

	fwd_entry_stage u_entry (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.status_i(status_i), .query_i(query_i), .ptr_curr_i(ptr_curr_i),
		.read_num_i(read_num_i), .ik_i(ik_in), .forward_i_i(forward_i_i),
		.min_intv_i(min_intv_i), .backward_x_i(backward_x_i), .ok_i(ok_in),
		.out(s0.src), .ok_o(ok_s0)
	);

	fwd_select_stage u_select (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.in(s0.dst), .ok_i(ok_s0), .out(s1.src), .ok_o(ok_s1), .update_ik_o(update_ik),
		.curr_read_num_o(curr_read_num_o), .curr_we_o(curr_we_o),
		.curr_data_o(curr_data_o), .curr_addr_o(curr_addr_o),
		.ret_valid_o(ret_valid_o), .ret_o(ret_o), .ret_read_num_o(ret_read_num_o)
	);

	fwd_update_stage u_update (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.in(s1.dst), .ok_i(ok_s1), .update_ik_i(update_ik), .out(s2.src),
		.k_pos_o(k_pos), .l_pos_o(l_pos), .k_pos_m1_o(k_pos_m1), .l_pos_m1_o(l_pos_m1)
	);

	fwd_mem_request_stage u_mem_req (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.primary_i(primary_i), .in(s2.dst),
		.k_pos_i(k_pos), .l_pos_i(l_pos), .k_pos_m1_i(k_pos_m1), .l_pos_m1_i(l_pos_m1),
		.dram_valid_o(dram_valid_o), .addr_k_o(addr_k_o), .addr_l_o(addr_l_o),
		.status_o(status_o), .ptr_curr_o(ptr_curr_o), .read_num_o(read_num_o),
		.ik_o(ik_out), .forward_i_o(forward_i_o), .min_intv_o(min_intv_o),
		.backward_x_o(backward_x_o), .next_query_position_o(next_query_position_o)
	);

endmodule

//--- sim/tb_fwd_ext.sv
`timescale 1ns/1ns
`include "fwd_ext_macros.svh"

module tb_fwd_ext import fwd_ext_pkg::*; ();

	typedef struct packed {
		logic [`STATUS_W-1:0]   status;
		logic [`QUERY_W-1:0]    query;
		logic [`POS_W-1:0]      ptr_curr;
		logic [`READ_NUM_W-1:0] read_num;
		bi_interval_t           ik;
		logic [`POS_W-1:0]      forward_i, min_intv, backward_x;
		ok_set_t                ok;
	} item_t;

	typedef struct packed {
		logic [8*12-1:0]        name;      // behaviour the item exercises
		logic                   curr_we, ret_valid, dram_valid;
		bi_interval_t           curr_data;
		logic [`POS_W-1:0]      curr_addr, ret;
		logic [`READ_NUM_W-1:0] curr_read_num, ret_read_num;
		logic [`ADDR_W-1:0]     addr_k, addr_l;
		item_t                  item;      // item leaving the mem request stage
	} exp_t;

	logic                   Clk_32UI, reset_BWT_extend, stall_i;
	logic [63:0]            primary_i;
	item_t                  cur;       // item at the DUT inputs
	logic                   dram_valid_o, curr_we_o, ret_valid_o;
	logic [`ADDR_W-1:0]     addr_k_o, addr_l_o;
	logic [`STATUS_W-1:0]   status_o;
	logic [`POS_W-1:0]      ptr_curr_o, forward_i_o, min_intv_o, backward_x_o;
	logic [`POS_W-1:0]      next_query_position_o, curr_addr_o, ret_o;
	logic [`READ_NUM_W-1:0] read_num_o, curr_read_num_o, ret_read_num_o;
	logic [63:0]            ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o;
	logic [255:0]           curr_data_o;

	logic [31:0] lfsr;
	exp_t        exp_q[$];  // one entry per edge the pipeline advanced on
	exp_t        es, em;
	int          n_adv, mem_done;
	bit          armed;
	logic        froze;     // last edge was stalled

	fwd_ext_top u_dut (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.primary_i(primary_i), .status_i(cur.status), .query_i(cur.query),
		.ptr_curr_i(cur.ptr_curr), .read_num_i(cur.read_num),
		.ik_x0_i(cur.ik.x0), .ik_x1_i(cur.ik.x1), .ik_x2_i(cur.ik.x2), .ik_info_i(cur.ik.info),
		.forward_i_i(cur.forward_i), .min_intv_i(cur.min_intv), .backward_x_i(cur.backward_x),
		.ok0_x0_i(cur.ok[0].x0), .ok0_x1_i(cur.ok[0].x1), .ok0_x2_i(cur.ok[0].x2),
		.ok1_x0_i(cur.ok[1].x0), .ok1_x1_i(cur.ok[1].x1), .ok1_x2_i(cur.ok[1].x2),
		.ok2_x0_i(cur.ok[2].x0), .ok2_x1_i(cur.ok[2].x1), .ok2_x2_i(cur.ok[2].x2),
		.ok3_x0_i(cur.ok[3].x0), .ok3_x1_i(cur.ok[3].x1), .ok3_x2_i(cur.ok[3].x2),
		.dram_valid_o(dram_valid_o), .addr_k_o(addr_k_o), .addr_l_o(addr_l_o),
		.status_o(status_o), .ptr_curr_o(ptr_curr_o), .read_num_o(read_num_o),
		.ik_x0_o(ik_x0_o), .ik_x1_o(ik_x1_o), .ik_x2_o(ik_x2_o), .ik_info_o(ik_info_o),
		.forward_i_o(forward_i_o), .min_intv_o(min_intv_o), .backward_x_o(backward_x_o),
		.next_query_position_o(next_query_position_o), .curr_read_num_o(curr_read_num_o),
		.curr_we_o(curr_we_o), .curr_data_o(curr_data_o), .curr_addr_o(curr_addr_o),
		.ret_valid_o(ret_valid_o), .ret_o(ret_o), .ret_read_num_o(ret_read_num_o)
	);

	initial begin
		Clk_32UI = 1'b0;
		forever #20 Clk_32UI = ~Clk_32UI;
	end

	// galois LFSR stepped once per bit taken
	function automatic logic [63:0] lfsr_bits(input int n);
		logic [63:0] v;
		int          b;
		v = '0;
		for (b = 0; b < n; b++) begin
			v    = {v[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BCD35C) : (lfsr >> 1);
		end
		return v;
	endfunction

	// put k or l of an interval on a block boundary now and then
	function automatic bi_interval_t align_block(input bi_interval_t iv);
		case (lfsr_bits(2))
			2'd0: iv.x1[6:0] = 7'd1;              // k = x1 - 1 starts a block
			2'd1: iv.x1[6:0] = 7'd1 - iv.x2[6:0]; // l = k + x2 starts a block
			default: ;
		endcase
		return iv;
	endfunction

	function automatic item_t random_item();
		item_t      it;
		logic [2:0] pick;
		int         b;
		it   = '0;
		pick = lfsr_bits(3);
		case (pick)
			3'd0: it.status = `ST_F_INIT;
			3'd1: it.status = `ST_F_BREAK;
			3'd2: it.status = `ST_BUBBLE;
			3'd3: it.status = `ST_BCK_INI;
			default: it.status = `ST_F_RUN;
		endcase
		it.query    = (lfsr_bits(3) == 0) ? 8'd4 + lfsr_bits(6) : lfsr_bits(2); // some ambiguous
		it.ptr_curr = lfsr_bits(`POS_W);
		it.read_num = lfsr_bits(`READ_NUM_W);
		it.ik.info  = lfsr_bits(64);
		it.ik.x2    = lfsr_bits(8); // small sizes so min_intv matters
		it.ik.x1    = lfsr_bits(64);
		it.ik.x0    = lfsr_bits(64);
		it.ik       = align_block(it.ik);
		pick        = lfsr_bits(3);
		if (pick == 0) it.forward_i = `READ_LEN;
		else if (pick == 1) it.forward_i = `READ_LEN + lfsr_bits(4);
		else it.forward_i = lfsr_bits(7) % `READ_LEN;
		it.min_intv   = lfsr_bits(`POS_W);
		it.backward_x = lfsr_bits(`POS_W);
		for (b = 0; b < 4; b++) begin
			it.ok[b].x0 = lfsr_bits(64);
			it.ok[b].x1 = lfsr_bits(64);
			it.ok[b].x2 = (lfsr_bits(2) == 0) ? it.ik.x2 : lfsr_bits(8);
			it.ok[b]    = align_block(it.ok[b]);
		end
		return it;
	endfunction

	// ----------------------------------------------------------
	// reference model of the forward step
	function automatic exp_t model_item(input item_t it, input logic [63:0] primary);
		exp_t         e;
		bi_interval_t cand;
		logic [63:0]  k, l;
		logic         upd;
		e      = '0;
		e.item = it;
		e.name = "other";
		upd    = 1'b0;
		cand   = it.ok[3 - it.query[1:0]]; // complement base
		if (it.status == `ST_F_RUN && it.forward_i >= `READ_LEN) begin
			e.item.status = `ST_F_BREAK;
			e.name        = "read_end";
		end
		if (e.item.status == `ST_F_RUN) begin
			e.curr_we     = (it.query > 3) || (cand.x2 != it.ik.x2);
			upd           = (it.query <= 3) && (cand.x2 == it.ik.x2 || cand.x2 >= 64'(it.min_intv));
			e.item.status = upd ? `ST_F_RUN : `ST_F_BREAK;
			e.name        = upd ? (e.curr_we ? "run_shrink" : "run_same") : "run_break";
		end
		else if (e.item.status == `ST_F_BREAK) begin
			e.curr_we     = (it.forward_i == `READ_LEN);
			e.ret_valid   = 1'b1;
			e.item.status = `ST_BCK_INI;
			if (it.status == `ST_F_BREAK) e.name = "break_in";
		end
		else if (it.status == `ST_F_INIT) e.name = "init";
		if (e.curr_we) begin
			e.curr_data       = it.ik; // old interval goes to curr
			e.curr_addr       = it.ptr_curr;
			e.curr_read_num   = it.read_num;
			e.item.ptr_curr   = it.ptr_curr + 1'b1;
		end
		if (e.ret_valid) begin
			e.ret          = it.ik.info[`POS_W-1:0];
			e.ret_read_num = it.read_num;
		end
		if (upd) begin
			e.item.forward_i = it.forward_i + 1'b1;
			e.item.ik        = {64'(e.item.forward_i), cand.x2, cand.x1, cand.x0};
		end
		k = e.item.ik.x1 - 64'd1;
		l = k + e.item.ik.x2;
		k = (k >= primary) ? k - 64'd1 : k; // skip the primary row
		l = (l >= primary) ? l - 64'd1 : l;
		e.dram_valid = (e.item.status == `ST_F_INIT) || (e.item.status == `ST_F_RUN);
		if (e.dram_valid) begin
			e.addr_k = {k[34:7], 4'b0000};
			e.addr_l = {l[34:7], 4'b0000};
		end
		if (e.item.status == `ST_F_INIT) e.item.status = `ST_F_RUN;
		return e;
	endfunction

	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input logic [8*12-1:0] test, input string field,
			input logic [255:0] expv, input logic [255:0] act);
		assert (act === expv) else begin
			$display("Error %0s %0s: expected %0h, actual %0h", test, field, expv, act);
			abort_run();
		end
	endtask

	// ----------------------------------------------------------
	// each edge the DUT advances on takes the item at the inputs
	always @(posedge Clk_32UI) begin
		froze <= reset_BWT_extend && stall_i;
		if (!reset_BWT_extend) armed <= 1'b1;
		else if (!stall_i) begin
			exp_q.push_back(model_item(cur, primary_i));
			n_adv <= n_adv + 1;
		end
	end

	// select outputs lag 2 advances and mem request outputs lag 5
	always @(negedge Clk_32UI) begin
		if (armed) begin
			es = '0;
			em = '0;
			if (n_adv >= 2) es = exp_q[n_adv-2];
			else es.name = "reset";
			if (n_adv >= 5) em = exp_q[n_adv-5];
			else begin
				em.name        = "reset";
				em.item.status = `ST_BUBBLE;
			end
			check_value(es.name, "curr_we_o", es.curr_we, curr_we_o);
			check_value(es.name, "ret_valid_o", es.ret_valid, ret_valid_o);
			if (es.curr_we) begin
				check_value(es.name, "curr_data_o", es.curr_data, curr_data_o);
				check_value(es.name, "curr_addr_o", es.curr_addr, curr_addr_o);
				check_value(es.name, "curr_read_num_o", es.curr_read_num, curr_read_num_o);
			end
			if (es.ret_valid) begin
				check_value(es.name, "ret_o", es.ret, ret_o);
				check_value(es.name, "ret_read_num_o", es.ret_read_num, ret_read_num_o);
			end
			check_value(em.name, "dram_valid_o", froze ? 1'b0 : em.dram_valid, dram_valid_o);
			check_value(em.name, "status_o", em.item.status, status_o);
			if (froze || em.dram_valid) begin // zero while frozen
				check_value(em.name, "addr_k_o", froze ? '0 : em.addr_k, addr_k_o);
				check_value(em.name, "addr_l_o", froze ? '0 : em.addr_l, addr_l_o);
			end
			if (n_adv >= 5) begin
				check_value(em.name, "ptr_curr_o", em.item.ptr_curr, ptr_curr_o);
				check_value(em.name, "read_num_o", em.item.read_num, read_num_o);
				check_value(em.name, "ik_o", em.item.ik, {ik_info_o, ik_x2_o, ik_x1_o, ik_x0_o});
				check_value(em.name, "forward_i_o", em.item.forward_i, forward_i_o);
				check_value(em.name, "min_intv_o", em.item.min_intv, min_intv_o);
				check_value(em.name, "backward_x_o", em.item.backward_x, backward_x_o);
				check_value(em.name, "next_query_position_o", em.item.forward_i,
					next_query_position_o);
				mem_done = n_adv - 4;
			end
		end
	end

	initial begin
		int target;
		int guard;
		lfsr             = 32'h106201b0;
		reset_BWT_extend = 1'b0;
		stall_i          = 1'b0;
		cur              = '0;
		cur.status       = `ST_BUBBLE;
		primary_i        = lfsr_bits(64);
		repeat (5) @(posedge Clk_32UI);
		#2 reset_BWT_extend = 1'b1;
		repeat (400) begin
			@(posedge Clk_32UI);
			#2;
			cur     = random_item();
			stall_i = (lfsr_bits(3) == 0); // about one cycle in eight
		end
		@(posedge Clk_32UI);
		#2;
		cur.status = `ST_BUBBLE;
		stall_i    = 1'b0;
		target     = n_adv + 1; // the next edge takes the last item if it was stalled
		guard      = 0;
		while (mem_done < target && guard < 50) begin
			@(posedge Clk_32UI);
			guard++;
		end
		if (mem_done < target) begin
			$display("pipeline did not deliver the last items within 50 cycles");
			abort_run();
		end
		else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

//--- fwd_ext.f
+incdir+include
src/fwd_ext_pkg.sv
src/ext_stage_if.sv
src/fwd_entry_stage.sv
src/fwd_select_stage.sv
src/fwd_update_stage.sv
src/fwd_mem_request_stage.sv
src/fwd_ext_top.sv
sim/tb_fwd_ext.sv
